/* vlog.f */
+incdir+include
verilog/cmvPkg.sv
verilog/spiRegPort.sv
verilog/frameSequencer.sv
verilog/rowCropper.sv
verilog/pixelFifo.sv
verilog/cmvCaptureTop.sv
dv/cmvCapture_sva.sv
dv/cmvCaptureTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cmvCaptureTb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cmvCaptureTb.sv */
`include "cmv_defs.svh"

module cmvCaptureTb;

    logic                   clk;
    logic                   rstN;
    logic                   spiStart;
    cmvPkg::spiCmdT         spiCmd;
    logic                   frameStart;
    cmvPkg::sensorInT       sensorIn;
    logic                   spiMiso;
    logic                   pixelRd;
    logic                   spiBusy, spiDone, sysResN, spiEn, spiSck, spiMosi;
    logic                   frameBusy, frameReq, frameDone;
    logic [`CMV_BYTE_W-1:0] readData, pixelData;
    logic                   pixelAvail, almostFull, overflow;

    int                     errCount = 0;
    logic [31:0]            lfsr = 32'd32;
    logic [`CMV_BYTE_W-1:0] expQ [$]; // bytes the fifo should hand out
    logic                   sawFrameDone;
    logic                   sawOverflow;

    cmvCaptureTop #(.frameRows(3)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // single cycle pulses latched on every cycle
    always @(negedge clk) begin
        if (frameDone) sawFrameDone = 1'b1;
        if (overflow) sawOverflow = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errCount++;
        end
    endtask

    task automatic timeoutErr(input string what);
        $display("timeout while waiting for %s", what);
        errCount++;
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [`CMV_PIXEL_W-1:0] nextPixel();
        logic [`CMV_PIXEL_W-1:0] pix;
        pix = '0;
        for (int i = 0; i < `CMV_PIXEL_W; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            pix  = {pix[`CMV_PIXEL_W-2:0], lfsr[0]};
        end
        return pix;
    endfunction

    // one register transfer with a slave that answers missByte on a read
    task automatic spiTransfer(input cmvPkg::spiCmdT cmd, input logic [7:0] missByte,
                               output logic [15:0] bits, output int enCycles,
                               output logic [7:0] rdData);
        int   rise = 0;
        int   t = 0;
        logic done = 1'b0;
        logic sckPrev = 1'b0;
        logic nextMiso;
        enCycles = 0;
        bits     = '0;
        @(posedge clk);
        spiStart <= 1'b1;
        spiCmd   <= cmd;
        while (!done && t < 200) begin
            @(negedge clk);
            if (spiEn) begin
                enCycles++;
                checkVal("spiBusy", 1, spiBusy);
            end
            if (spiSck && !sckPrev) begin
                bits = {bits[14:0], spiMosi}; // mosi stable over high phase
                rise++;
            end
            nextMiso = 1'b0;
            if (spiEn && !spiSck && rise >= 8 && rise < 16) nextMiso = missByte[15-rise];
            sckPrev = spiSck;
            if (spiDone) begin
                done   = 1'b1;
                rdData = readData;
            end
            @(posedge clk);
            spiStart <= 1'b0;
            spiMiso  <= nextMiso;
            t++;
        end
        if (!done) timeoutErr("spiDone");
    endtask

    // pulses frameStart and counts cycles until frameReq
    task automatic startFrame(output int latency);
        latency = 0;
        @(posedge clk);
        frameStart <= 1'b1;
        @(posedge clk);
        frameStart <= 1'b0;
        do begin
            @(negedge clk);
            latency++;
        end while (!frameReq && latency < `CMV_SETTLE_CYCLES + 500);
        if (!frameReq) timeoutErr("frameReq");
    endtask

    // sensor model sending rows of lfsr pixels with idle gaps
    task automatic sendRows(input int rows);
        logic [`CMV_PIXEL_W-1:0] pix;
        for (int r = 0; r < rows; r++) begin
            for (int p = 0; p < `CMV_ROW_PIXELS; p++) begin
                pix = nextPixel();
                @(posedge clk);
                sensorIn.dataValid <= 1'b1;
                sensorIn.data      <= pix;
                if (p >= `CMV_CROP_LEFT && p < `CMV_ROW_PIXELS - `CMV_CROP_RIGHT)
                    expQ.push_back(pix[`CMV_PIXEL_W-1 -: `CMV_BYTE_W]);
            end
            repeat (200) begin
                @(posedge clk);
                sensorIn.dataValid <= 1'b0;
            end
        end
    endtask

    // host reader taking one byte every two cycles
    task automatic drainCheck(input int count);
        int got = 0;
        int t = 0;
        while (got < count && t < 20000) begin
            @(negedge clk);
            if (pixelAvail && expQ.size() > 0) begin
                checkVal("pixelData", expQ.pop_front(), pixelData);
                got++;
                @(posedge clk) pixelRd <= 1'b1;
                @(posedge clk) pixelRd <= 1'b0;
            end
            t++;
        end
        if (got < count) timeoutErr("pixel bytes from the fifo");
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic spiWriteTest();
        cmvPkg::spiCmdT cmd;
        logic [15:0]    bits;
        logic [7:0]     rd;
        int             en;
        cmd = '{write: 1'b1, addr: 7'h2A, data: 8'hC3};
        spiTransfer(cmd, 8'h00, bits, en, rd);
        checkVal("spiMosi bits", {cmd.write, cmd.addr, cmd.data}, bits);
        checkVal("spiEn cycles", 34, en);
        checkVal("sysResN", 1, sysResN);
    endtask

    task automatic spiReadTest();
        cmvPkg::spiCmdT cmd;
        logic [15:0]    bits;
        logic [7:0]     rd;
        int             en;
        cmd = '{write: 1'b0, addr: 7'h15, data: 8'hFF};
        spiTransfer(cmd, 8'h5B, bits, en, rd);
        checkVal("spiMosi bits", {1'b0, cmd.addr, 8'h00}, bits); // data zero on read
        checkVal("readData", 8'h5B, rd);
    endtask

    task automatic frameRequestTest();
        int lat;
        startFrame(lat);
        checkVal("frameReq latency", `CMV_SETTLE_CYCLES + 1, lat);
        checkVal("frameBusy", 1, frameBusy);
        @(negedge clk);
        checkVal("frameReq second cycle", 0, frameReq);
    endtask

    // runs in the frame opened by frameRequestTest
    task automatic cropTest();
        int want;
        want = 3 * (`CMV_ROW_PIXELS - `CMV_CROP_LEFT - `CMV_CROP_RIGHT);
        sawFrameDone = 1'b0;
        sawOverflow  = 1'b0;
        fork
            sendRows(3);
            drainCheck(want);
        join
        checkVal("frameDone seen", 1, sawFrameDone);
        checkVal("overflow", 0, sawOverflow);
        checkVal("leftover bytes", 0, expQ.size());
        checkVal("frameBusy", 0, frameBusy); // back to idle after the last row
    endtask

    task automatic overflowTest();
        int lat;
        int t = 0;
        startFrame(lat);
        sendRows(3);
        @(negedge clk);
        checkVal("almostFull", 1, almostFull);
        checkVal("overflow", 1, overflow);
        drainCheck(`CMV_FIFO_DEPTH);
        expQ.delete();
        @(negedge clk);
        checkVal("pixelAvail", 0, pixelAvail); // dropped beats never stored
        @(posedge clk) pixelRd <= 1'b1; // stray read on an empty fifo
        @(posedge clk) pixelRd <= 1'b0;
        @(negedge clk);
        checkVal("pixelAvail", 0, pixelAvail);
        @(posedge clk);
        frameStart <= 1'b1;
        @(posedge clk);
        frameStart <= 1'b0;
        while (overflow && t < 10) begin
            @(negedge clk);
            t++;
        end
        if (overflow) timeoutErr("overflow to clear");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rstN       = 1'b0;
        spiStart   = 1'b0;
        spiCmd     = '0;
        frameStart = 1'b0;
        sensorIn   = '0;
        spiMiso    = 1'b0;
        pixelRd    = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkVal("sysResN after reset", 0, sysResN);
        spiWriteTest();
        spiReadTest();
        frameRequestTest();
        cropTest();
        overflowTest();
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* dv/cmvCapture_sva.sv */
`include "cmv_defs.svh"

module cmvCapture_sva (
    input logic                            clk,
    input logic                            rstN,
    input logic                            spiEn,
    input logic                            spiSck,
    input logic                            frameReq,
    input logic                            pixelAvail,
    input logic                            beatValid,
    input logic [$clog2(`CMV_FIFO_DEPTH):0] fillCount
);

    //////////////////////////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////////////////////////

    // sck only moves inside a transfer
    sckInsideEn: assert property (@(posedge clk) disable iff (!rstN)
        $changed(spiSck) |-> spiEn)
        else $error("spiSck toggled with spiEn low");

    reqSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
        frameReq |=> !frameReq)
        else $error("frameReq high for two cycles");

    // stray read on an empty fifo leaves it empty
    emptyStaysEmpty: assert property (@(posedge clk) disable iff (!rstN)
        (fillCount == '0 && !beatValid) |=> !pixelAvail)
        else $error("pixelAvail rose on an empty fifo with no beat");

endmodule

bind cmvCaptureTop cmvCapture_sva i_sva (
    .clk(clk), .rstN(rstN), .spiEn(spiEn), .spiSck(spiSck),
    .frameReq(frameReq), .pixelAvail(pixelAvail),
    .beatValid(pixelBeat.valid),
    .fillCount(i_fifo.fillCount)
);

/* verilog/cmvCaptureTop.sv */
`include "cmv_defs.svh"

module cmvCaptureTop #(
    parameter int frameRows = `CMV_FRAME_ROWS
) (
    input  logic                   clk,
    input  logic                   rstN,
    // register access
    input  logic                   spiStart,
    input  cmvPkg::spiCmdT         spiCmd,
    output logic                   spiBusy,
    output logic                   spiDone,
    output logic [`CMV_BYTE_W-1:0] readData,
    // sensor pins
    input  logic                   spiMiso,
    output logic                   sysResN,
    output logic                   spiEn,
    output logic                   spiSck,
    output logic                   spiMosi,
    output logic                   frameReq,
    input  cmvPkg::sensorInT       sensorIn,
    // frame control
    input  logic                   frameStart,
    output logic                   frameBusy,
    output logic                   frameDone,
    // host read side
    input  logic                   pixelRd,
    output logic [`CMV_BYTE_W-1:0] pixelData,
    output logic                   pixelAvail,
    output logic                   almostFull,
    output logic                   overflow
);

    logic              streamEn;
    logic              rowDone;
    cmvPkg::pixelBeatT pixelBeat;

    //////////////////////////////////////////////////////////////////////
    // side branch, sensor register port
    //////////////////////////////////////////////////////////////////////

    spiRegPort i_spi (
        .clk(clk), .rstN(rstN),
        .spiStart(spiStart), .spiCmd(spiCmd), .spiMiso(spiMiso),
        .spiBusy(spiBusy), .spiDone(spiDone), .readData(readData),
        .sysResN(sysResN), .spiEn(spiEn), .spiSck(spiSck), .spiMosi(spiMosi)
    );

    //////////////////////////////////////////////////////////////////////
    // frame pipeline, sequencer then cropper then fifo
    //////////////////////////////////////////////////////////////////////

    frameSequencer #(.frameRows(frameRows)) i_seq (
        .clk(clk), .rstN(rstN),
        .frameStart(frameStart), .rowDone(rowDone),
        .frameBusy(frameBusy), .frameReq(frameReq),
        .streamEn(streamEn), .frameDone(frameDone)
    );

    rowCropper i_crop (
        .clk(clk), .rstN(rstN),
        .streamEn(streamEn), .sensorIn(sensorIn),
        .pixelBeat(pixelBeat), .rowDone(rowDone)
    );

    pixelFifo i_fifo (
        .clk(clk), .rstN(rstN),
        .pixelBeat(pixelBeat), .pixelRd(pixelRd),
        .frameBusy(frameBusy), // rising edge clears overflow
        .pixelData(pixelData), .pixelAvail(pixelAvail),
        .almostFull(almostFull), .overflow(overflow)
    );

endmodule

/* verilog/pixelFifo.sv */
`include "cmv_defs.svh"

module pixelFifo (
    input  logic                   clk,
    input  logic                   rstN,
    input  cmvPkg::pixelBeatT      pixelBeat,
    input  logic                   pixelRd,
    input  logic                   frameBusy,
    output logic [`CMV_BYTE_W-1:0] pixelData,
    output logic                   pixelAvail,
    output logic                   almostFull,
    output logic                   overflow
);

    localparam int AW = $clog2(`CMV_FIFO_DEPTH);

    logic [`CMV_BYTE_W-1:0] mem [`CMV_FIFO_DEPTH];
    logic [AW-1:0]          wrPtr;
    logic [AW-1:0]          rdPtr;
    logic [AW:0]            fillCount; // one extra bit for full
    logic                   full;
    logic                   wrEn;
    logic                   rdEn;
    logic                   frameBusyPrev;
    logic                   clearOverflow;

    assign full          = (fillCount == (AW+1)'(`CMV_FIFO_DEPTH));
    assign wrEn          = pixelBeat.valid && !full; // sensor never stalls
    assign rdEn          = pixelRd && pixelAvail;    // stray reads ignored
    assign clearOverflow = frameBusy && !frameBusyPrev; // new frame accepted

    //////////////////////////////////////////////////////////////////////
    // pointers, fill level, flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            fillCount     <= '0;
            overflow      <= 1'b0;
            frameBusyPrev <= 1'b0;
        end else begin
            frameBusyPrev <= frameBusy;
            if (wrEn) wrPtr <= wrPtr + 1'b1; // depth is a power of two, wraps
            if (rdEn) rdPtr <= rdPtr + 1'b1;
            fillCount <= fillCount + (AW+1)'(wrEn) - (AW+1)'(rdEn);
            if (pixelBeat.valid && full) begin
                overflow <= 1'b1; // beat lost
            end else if (clearOverflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) mem[wrPtr] <= pixelBeat.data;
    end

    // show-ahead, head entry always on the output
    assign pixelData  = mem[rdPtr];
    assign pixelAvail = (fillCount != '0);
    assign almostFull = (fillCount >= (AW+1)'(`CMV_ALMOST_FULL));

endmodule

/* verilog/rowCropper.sv */
`include "cmv_defs.svh"

module rowCropper (
    input  logic                clk,
    input  logic                rstN,
    input  logic                streamEn,
    input  cmvPkg::sensorInT    sensorIn,
    output cmvPkg::pixelBeatT   pixelBeat,
    output logic                rowDone
);

    localparam int CNT_W = $clog2(`CMV_ROW_PIXELS + 1);
    localparam int FIRST_PIX = `CMV_CROP_LEFT;
    localparam int LAST_PIX = `CMV_ROW_PIXELS - `CMV_CROP_RIGHT - 1;

    logic [CNT_W-1:0]       pixCnt; // pixels seen in this row, saturates
    logic                   dvPrev;
    logic                   beatValid;
    logic [`CMV_BYTE_W-1:0] beatData;
    logic                   inWindow;
    logic                   rowFull;
    logic                   dvFall;

    assign inWindow = (pixCnt >= CNT_W'(FIRST_PIX)) && (pixCnt <= CNT_W'(LAST_PIX));
    assign rowFull  = (pixCnt == CNT_W'(`CMV_ROW_PIXELS));
    assign dvFall   = dvPrev && !sensorIn.dataValid;

    //////////////////////////////////////////////////////////////////////
    // pixel counter and row end
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pixCnt    <= '0;
            dvPrev    <= 1'b0;
            beatValid <= 1'b0;
            rowDone   <= 1'b0;
        end else begin
            dvPrev    <= sensorIn.dataValid;
            beatValid <= 1'b0;
            rowDone   <= 1'b0;
            if (!streamEn) begin
                pixCnt <= '0; // next frame starts clean
            end else if (dvFall && rowFull) begin
                pixCnt  <= '0;
                rowDone <= 1'b1;
            end else if (sensorIn.dataValid) begin
                beatValid <= inWindow; // drop the dark edges
                if (!rowFull) pixCnt <= pixCnt + 1'b1;
            end
        end
    end

    // upper bits only, lsbs are mostly noise
    always_ff @(posedge clk) begin
        beatData <= sensorIn.data[`CMV_PIXEL_W-1 -: `CMV_BYTE_W];
    end

    assign pixelBeat.valid = beatValid;
    assign pixelBeat.data  = beatData;

endmodule

/* verilog/frameSequencer.sv */
`include "cmv_defs.svh"

module frameSequencer #(
    parameter int frameRows = `CMV_FRAME_ROWS
) (
    input  logic clk,
    input  logic rstN,
    input  logic frameStart,
    input  logic rowDone,
    output logic frameBusy,
    output logic frameReq,
    output logic streamEn,
    output logic frameDone
);

    localparam int SETTLE_W = $clog2(`CMV_SETTLE_CYCLES);
    localparam int ROW_W = $clog2(frameRows + 1);

    cmvPkg::seqStateT    state;
    logic [SETTLE_W-1:0] settleCnt;
    logic [ROW_W-1:0]    rowCnt; // rows finished this frame

    //////////////////////////////////////////////////////////////////////
    // sequencer FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= cmvPkg::SEQ_IDLE;
            settleCnt <= '0;
            rowCnt    <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0; // single cycle pulse
            case (state)
                cmvPkg::SEQ_IDLE: begin
                    if (frameStart) begin
                        state     <= cmvPkg::SEQ_SETTLE;
                        settleCnt <= '0;
                    end
                end
                cmvPkg::SEQ_SETTLE: begin
                    // exactly SETTLE cycles spent here
                    if (settleCnt == SETTLE_W'(`CMV_SETTLE_CYCLES - 1)) begin
                        state <= cmvPkg::SEQ_REQUEST;
                    end else begin
                        settleCnt <= settleCnt + 1'b1;
                    end
                end
                cmvPkg::SEQ_REQUEST: begin
                    state  <= cmvPkg::SEQ_STREAM;
                    rowCnt <= '0;
                end
                cmvPkg::SEQ_STREAM: begin
                    if (rowDone) begin
                        if (rowCnt == ROW_W'(frameRows - 1)) begin
                            state     <= cmvPkg::SEQ_IDLE; // last row in
                            frameDone <= 1'b1;
                        end else begin
                            rowCnt <= rowCnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    assign frameBusy = (state != cmvPkg::SEQ_IDLE);
    assign frameReq  = (state == cmvPkg::SEQ_REQUEST);
    assign streamEn  = (state == cmvPkg::SEQ_STREAM);

endmodule

/* verilog/spiRegPort.sv */
`include "cmv_defs.svh"

module spiRegPort (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   spiStart,
    input  cmvPkg::spiCmdT         spiCmd,
    input  logic                   spiMiso,
    output logic                   spiBusy,
    output logic                   spiDone,
    output logic [`CMV_BYTE_W-1:0] readData,
    output logic                   sysResN,
    output logic                   spiEn,
    output logic                   spiSck,
    output logic                   spiMosi
);

    localparam int CMD_W = $bits(cmvPkg::spiCmdT); // 16 bits on the wire
    localparam int IDX_W = $clog2(CMD_W);
    localparam int DATA_FIRST = 1 + `CMV_ADDR_W; // first data bit index

    cmvPkg::spiStateT state;
    logic             phase; // 0 = sck low half, 1 = sck high half
    logic [IDX_W-1:0] bitIdx;

    logic [CMD_W-1:0]       shiftReg; // outgoing, msb on mosi
    logic [`CMV_BYTE_W-1:0] rxShift;
    logic                   writeOp;

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= cmvPkg::SPI_IDLE;
            phase    <= 1'b0;
            bitIdx   <= '0;
            sysResN  <= 1'b0; // sensor held in reset until first command
            readData <= '0;
        end else begin
            case (state)
                cmvPkg::SPI_IDLE: begin
                    if (spiStart) begin
                        state   <= cmvPkg::SPI_ENABLE;
                        sysResN <= 1'b1; // sticky from here on
                    end
                end
                cmvPkg::SPI_ENABLE: begin
                    state  <= cmvPkg::SPI_SHIFT;
                    phase  <= 1'b0;
                    bitIdx <= '0;
                end
                cmvPkg::SPI_SHIFT: begin
                    if (!phase) begin
                        phase <= 1'b1;
                    end else begin
                        phase <= 1'b0;
                        if (bitIdx == IDX_W'(CMD_W - 1)) begin
                            state <= cmvPkg::SPI_TAIL; // all bits out
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end
                cmvPkg::SPI_TAIL: begin
                    state <= cmvPkg::SPI_DISABLE;
                    if (!writeOp) readData <= rxShift; // present with done
                end
                cmvPkg::SPI_DISABLE: state <= cmvPkg::SPI_IDLE;
                default:             state <= cmvPkg::SPI_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shift registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == cmvPkg::SPI_IDLE && spiStart) begin
            // data field forced to zero on a read
            shiftReg <= {spiCmd.write, spiCmd.addr,
                         spiCmd.data & {`CMV_BYTE_W{spiCmd.write}}};
            writeOp  <= spiCmd.write;
        end else if (state == cmvPkg::SPI_SHIFT && phase) begin
            shiftReg <= {shiftReg[CMD_W-2:0], 1'b0}; // next bit on low phase
            if (bitIdx >= IDX_W'(DATA_FIRST)) begin
                rxShift <= {rxShift[`CMV_BYTE_W-2:0], spiMiso}; // sample on high
            end
        end
    end

    // pin decode
    assign spiBusy = (state != cmvPkg::SPI_IDLE);
    assign spiDone = (state == cmvPkg::SPI_DISABLE);
    assign spiEn   = (state == cmvPkg::SPI_ENABLE) || (state == cmvPkg::SPI_SHIFT) ||
                     (state == cmvPkg::SPI_TAIL);
    assign spiSck  = (state == cmvPkg::SPI_SHIFT) && phase;
    assign spiMosi = spiEn && shiftReg[CMD_W-1]; // low outside a transfer

endmodule

/* verilog/cmvPkg.sv */
`include "cmv_defs.svh"

package cmvPkg;

    //////////////////////////////////////////////////////////////////////
    // spi register port
    //////////////////////////////////////////////////////////////////////

    // shifted out msb first, write flag leads
    typedef struct packed {
        logic                   write; // 1 = write, 0 = read back
        logic [`CMV_ADDR_W-1:0] addr;
        logic [`CMV_BYTE_W-1:0] data; // ignored on a read
    } spiCmdT;

    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_ENABLE,  // en up, sck still low
        SPI_SHIFT,   // 16 bits, low then high phase each
        SPI_TAIL,    // last low phase
        SPI_DISABLE  // en down, done pulse
    } spiStateT;

    //////////////////////////////////////////////////////////////////////
    // frame pipeline
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SETTLE,
        SEQ_REQUEST, // single cycle
        SEQ_STREAM
    } seqStateT;

    // cropper to fifo, one per cycle
    typedef struct packed {
        logic                   valid;
        logic [`CMV_BYTE_W-1:0] data;
    } pixelBeatT;

    // raw sensor pins
    typedef struct packed {
        logic                    dataValid;
        logic [`CMV_PIXEL_W-1:0] data;
    } sensorInT;

endpackage

/* include/cmv_defs.svh */
`ifndef CMV_DEFS_SVH
`define CMV_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// sensor pixel bus
//////////////////////////////////////////////////////////////////////

`define CMV_PIXEL_W 10 // raw sensor pixel
`define CMV_BYTE_W 8 // stored pixel, spi data
`define CMV_ADDR_W 7 // spi register address

// row geometry, crop drops the dark columns on both edges
`define CMV_ROW_PIXELS 648
`define CMV_CROP_LEFT 4
`define CMV_CROP_RIGHT 4

//////////////////////////////////////////////////////////////////////
// frame timing
//////////////////////////////////////////////////////////////////////

`define CMV_SETTLE_CYCLES 2500 // start to frame request
`define CMV_FRAME_ROWS 480 // default rows per frame

//////////////////////////////////////////////////////////////////////
// pixel buffer
//////////////////////////////////////////////////////////////////////

`define CMV_FIFO_DEPTH 1024
`define CMV_ALMOST_FULL 896 // host should start draining here

`endif
